// File: common/mesm6_cfg.svh
// Widths, reset PC and long-format command codes of the MESM-6 address front end.
// Included by the package, the RTL and the testbench.
`ifndef MESM6_CFG_SVH
`define MESM6_CFG_SVH

//--------------------------------------------------------------------------
// data path widths
//--------------------------------------------------------------------------
`define MESM6_ADDR_BITS 15          // word address
`define MESM6_WORD_BITS 48          // instruction word, two halves
`define MESM6_INSN_BITS 24          // one instruction

//--------------------------------------------------------------------------
// program counter
//--------------------------------------------------------------------------
// half-word PC, word address above bit 0
`define MESM6_RESET_PC 16'h0000

//--------------------------------------------------------------------------
// long-format commands, opcode minus octal 020
//--------------------------------------------------------------------------
`define MESM6_LCMD_UTC 4'h2         // utc, octal 022
`define MESM6_LCMD_VTM 4'h4         // vtm, octal 024
`define MESM6_LCMD_UTM 4'h5         // utm, octal 025

`endif

// File: common/mesm6_pkg.sv
// Types shared by the fetch, decode and pipeline stages of the address front end.
`default_nettype none
`include "mesm6_cfg.svh"

package mesm6_pkg;

    typedef logic [`MESM6_ADDR_BITS-1:0] addr_t;    // word address
    typedef logic [`MESM6_ADDR_BITS:0]   hpc_t;     // word address, half select in bit 0
    typedef logic [`MESM6_WORD_BITS-1:0] word_t;    // instruction word
    typedef logic [`MESM6_INSN_BITS-1:0] insn_t;    // one instruction
    typedef logic [3:0]                  reg_idx_t; // index register number

    //----------------------------------------------------------------------
    // pipeline records
    //----------------------------------------------------------------------
    // one half-word out of fetch
    typedef struct packed {
        hpc_t  hpc;             // where it came from
        insn_t insn;
    } fetch_item_t;

    // decoded instruction with its executive address
    typedef struct packed {
        hpc_t  hpc;
        insn_t insn;
        addr_t uaddr;           // addr + C + M[ir]
    } agu_item_t;

    // index register write port
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        addr_t    data;
    } index_wr_t;

endpackage

`default_nettype wire

// File: hw/mesm6_stage_reg.sv
// One-entry valid/ready pipeline register, payload type given by parameter.
`timescale 1ns/100ps
`default_nettype none

module mesm6_stage_reg #(
    parameter type item_t = logic
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    output logic       in_ready,
    input  wire item_t in_item,
    output logic       out_valid,
    input  wire        out_ready,
    output item_t      out_item
);

    logic  valid_q;             // entry full
    item_t item_q;              // held payload

    // free slot, or the held item leaves this cycle
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_item  = item_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;    // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            item_q <= in_item;
        end
    end

    // stalled output must not change under the consumer
    a_hold_stable : assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_item))
        else $error("stage register output changed while stalled");

endmodule

`default_nettype wire

// File: hw/fetch/mesm6_fetch.sv
// Instruction fetch: half-word PC, one-word instruction cache and memory request.
// Hands out instructions left half first on a valid/ready stream.
`timescale 1ns/100ps
`default_nettype none
`include "mesm6_cfg.svh"

module mesm6_fetch (
    input  wire                           clk,
    input  wire                           reset,
    output logic                          fetch_valid,
    input  wire                           fetch_ready,
    output mesm6_pkg::addr_t              fetch_addr,
    input  wire                           rsp_valid,
    input  wire mesm6_pkg::word_t         rsp_word,
    output logic                          item_valid,
    input  wire                           item_ready,
    output mesm6_pkg::fetch_item_t        item
);

    mesm6_pkg::hpc_t  pc_q;             // half-word program counter
    mesm6_pkg::word_t cache_word_q;     // last word read
    mesm6_pkg::addr_t cache_addr_q;     // its word address
    logic             cache_valid_q;
    logic             req_q;            // request offered to memory
    logic             pending_q;        // accepted, waiting for the word
    logic             hit;
    mesm6_pkg::insn_t half;

    assign hit = cache_valid_q && (cache_addr_q == pc_q[`MESM6_ADDR_BITS:1]);

    // pc bit 0 picks the half, left one first
    assign half = pc_q[0] ? cache_word_q[`MESM6_INSN_BITS-1:0]
                          : cache_word_q[`MESM6_WORD_BITS-1:`MESM6_INSN_BITS];

    assign fetch_valid = req_q;
    assign fetch_addr  = pc_q[`MESM6_ADDR_BITS:1];  // pc holds during a miss
    assign item_valid  = hit;
    assign item        = '{hpc: pc_q, insn: half};

    //----------------------------------------------------------------------
    // program counter, counts up only
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `MESM6_RESET_PC;
        end else if (item_valid && item_ready) begin
            pc_q <= pc_q + 1'b1;            // next half, maybe next word
        end
    end

    //----------------------------------------------------------------------
    // memory request and response
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q     <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (fetch_valid && fetch_ready) begin
                req_q     <= 1'b0;
                pending_q <= 1'b1;          // one outstanding at most
            end else if (!hit && !req_q && !pending_q) begin
                req_q <= 1'b1;              // miss, go ask memory
            end
            if (rsp_valid) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cache_valid_q <= 1'b0;
        end else if (rsp_valid) begin
            cache_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            cache_word_q <= rsp_word;
            cache_addr_q <= pc_q[`MESM6_ADDR_BITS:1];   // same as requested
        end
    end

    a_rsp_pending : assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> pending_q)
        else $error("memory response without an outstanding request");

endmodule

`default_nettype wire

// File: hw/decode/mesm6_index_regs.sv
// Index registers M1..M15, M0 hardwired to zero; one async read, one write port.
`timescale 1ns/100ps
`default_nettype none

module mesm6_index_regs (
    input  wire                         clk,
    input  wire                         reset,
    input  wire mesm6_pkg::reg_idx_t    rd_idx,
    output mesm6_pkg::addr_t            rd_data,
    input  wire mesm6_pkg::index_wr_t   wr
);

    mesm6_pkg::addr_t m_q [1:15];       // no storage for M0

    assign rd_data = (rd_idx == 4'd0) ? '0 : m_q[rd_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 16; i++) begin
                m_q[i] <= '0;
            end
        end else if (wr.en && (wr.idx != 4'd0)) begin
            m_q[wr.idx] <= wr.data;     // M0 writes dropped
        end
    end

    // decode is expected to filter M0 writes itself
    a_no_m0_write : assert property (@(posedge clk) disable iff (reset)
        !(wr.en && (wr.idx == 4'd0)))
        else $error("index register write to M0");

endmodule

`default_nettype wire

// File: hw/decode/mesm6_decode.sv
// Decode stage: opcode fields, full and executive address, and the index
// instructions vtm, utm and utc executed in place.
`timescale 1ns/100ps
`default_nettype none
`include "mesm6_cfg.svh"

module mesm6_decode (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire mesm6_pkg::fetch_item_t   in_item,
    output logic                          out_valid,
    input  wire                           out_ready,
    output mesm6_pkg::agu_item_t          out_item,
    output mesm6_pkg::reg_idx_t           m_idx,
    input  wire mesm6_pkg::addr_t         m_data,
    output mesm6_pkg::index_wr_t          m_wr
);

    mesm6_pkg::insn_t    insn;
    mesm6_pkg::reg_idx_t op_ir;         // index register
    logic                op_lflag;      // long format
    logic [3:0]          op_lcmd;       // long command, minus 020
    mesm6_pkg::addr_t    op_addr;       // address field
    mesm6_pkg::addr_t    full_addr;     // addr + C
    mesm6_pkg::addr_t    exec_addr;     // addr + C + M[ir]
    mesm6_pkg::addr_t    c_q;           // C modifier
    logic                c_active_q;    // C applies to this instruction
    logic                is_vtm;
    logic                is_utm;
    logic                is_utc;
    logic                fire;

    //----------------------------------------------------------------------
    // fields
    //----------------------------------------------------------------------
    assign insn     = in_item.insn;
    assign op_ir    = insn[23:20];
    assign op_lflag = insn[19];
    assign op_lcmd  = insn[18:15];
    assign op_addr  = op_lflag ? insn[14:0]
                               : {{3{insn[18]}}, insn[11:0]};  // short, sign from bit 18

    assign is_vtm = op_lflag && (op_lcmd == `MESM6_LCMD_VTM);
    assign is_utm = op_lflag && (op_lcmd == `MESM6_LCMD_UTM);
    assign is_utc = op_lflag && (op_lcmd == `MESM6_LCMD_UTC);

    //----------------------------------------------------------------------
    // address formation
    //----------------------------------------------------------------------
    assign full_addr = c_active_q ? op_addr + c_q : op_addr;
    assign m_idx     = op_ir;
    assign exec_addr = full_addr + m_data;      // M0 reads zero

    // no state in the path, handshake goes straight through
    assign fire      = in_valid && out_ready;
    assign in_ready  = out_ready;
    assign out_valid = in_valid;
    assign out_item  = '{hpc: in_item.hpc, insn: insn, uaddr: exec_addr};

    // vtm takes the full address, utm the executive one
    assign m_wr = '{en:   fire && (is_vtm || is_utm) && (op_ir != 4'd0),
                    idx:  op_ir,
                    data: is_vtm ? full_addr : exec_addr};

    //----------------------------------------------------------------------
    // C modifier, good for one instruction after utc
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            c_active_q <= 1'b0;
            c_q        <= '0;
        end else if (fire) begin
            c_active_q <= is_utc;       // anything else drops it
            if (is_utc) begin
                c_q <= exec_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mesm6_agu.sv
// Top of the MESM-6 address front end: fetch, stage register, decode with
// index registers, output stage register.
`timescale 1ns/100ps
`default_nettype none

module mesm6_agu (
    input  wire                       clk,
    input  wire                       reset,
    output logic                      fetch_valid,
    input  wire                       fetch_ready,
    output mesm6_pkg::addr_t          fetch_addr,
    input  wire                       rsp_valid,
    input  wire mesm6_pkg::word_t     rsp_word,
    output logic                      out_valid,
    input  wire                       out_ready,
    output mesm6_pkg::agu_item_t      out_item
);

    logic                   f_valid, f_ready;   // fetch to first stage
    mesm6_pkg::fetch_item_t f_item;
    logic                   d_valid, d_ready;   // first stage to decode
    mesm6_pkg::fetch_item_t d_item;
    logic                   a_valid, a_ready;   // decode to output stage
    mesm6_pkg::agu_item_t   a_item;
    mesm6_pkg::reg_idx_t    m_idx;
    mesm6_pkg::addr_t       m_data;
    mesm6_pkg::index_wr_t   m_wr;

    mesm6_fetch i_fetch (
        .clk(clk), .reset(reset),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
        .rsp_valid(rsp_valid), .rsp_word(rsp_word),
        .item_valid(f_valid), .item_ready(f_ready), .item(f_item)
    );

    mesm6_stage_reg #(.item_t(mesm6_pkg::fetch_item_t)) i_fetch_stage (
        .clk(clk), .reset(reset),
        .in_valid(f_valid), .in_ready(f_ready), .in_item(f_item),
        .out_valid(d_valid), .out_ready(d_ready), .out_item(d_item)
    );

    mesm6_decode i_decode (
        .clk(clk), .reset(reset),
        .in_valid(d_valid), .in_ready(d_ready), .in_item(d_item),
        .out_valid(a_valid), .out_ready(a_ready), .out_item(a_item),
        .m_idx(m_idx), .m_data(m_data), .m_wr(m_wr)
    );

    mesm6_index_regs i_index_regs (
        .clk(clk), .reset(reset),
        .rd_idx(m_idx), .rd_data(m_data), .wr(m_wr)
    );

    mesm6_stage_reg #(.item_t(mesm6_pkg::agu_item_t)) i_out_stage (
        .clk(clk), .reset(reset),
        .in_valid(a_valid), .in_ready(a_ready), .in_item(a_item),
        .out_valid(out_valid), .out_ready(out_ready), .out_item(out_item)
    );

endmodule

`default_nettype wire

// File: tb/mesm6_agu_tb_table.svh
// Instruction table for the address front end testbench, two entries per memory word.
// Columns: ir, long flag, command, address field, expected executive address.

localparam int n_entries = 28;

typedef struct packed {
    logic [3:0]  ir;
    logic        lflag;     // 1 long format, 0 short
    logic [6:0]  cmd;       // long format uses bits 3:0
    logic [14:0] addr;      // short format uses bits 11:0
    logic [14:0] uaddr;     // expected executive address
} entry_t;

localparam entry_t entry_table [0:n_entries-1] = '{
    //  ir     l     cmd    addr      uaddr
    {4'd0,  1'b1, 7'h00, 15'h1234, 15'h1234},     // long field as is
    {4'd0,  1'b0, 7'h10, 15'h0abc, 15'h0abc},     // short, bit 18 clear
    {4'd0,  1'b0, 7'h50, 15'h0123, 15'h7123},     // short, bit 18 set
    {4'd3,  1'b1, 7'h00, 15'h7fff, 15'h7fff},
    {4'd3,  1'b1, 7'h04, 15'h0100, 15'h0100},     // vtm, M3 = 0100
    {4'd3,  1'b1, 7'h00, 15'h0020, 15'h0120},
    {4'd3,  1'b0, 7'h20, 15'h0005, 15'h0105},
    {4'd5,  1'b1, 7'h04, 15'h7f00, 15'h7f00},     // vtm, M5 = 7f00
    {4'd5,  1'b1, 7'h03, 15'h0200, 15'h0100},     // wraps mod 2^15
    {4'd5,  1'b1, 7'h05, 15'h0010, 15'h7f10},     // utm, M5 = 7f10
    {4'd5,  1'b1, 7'h00, 15'h0000, 15'h7f10},
    {4'd0,  1'b1, 7'h04, 15'h0555, 15'h0555},     // vtm on M0 dropped
    {4'd0,  1'b1, 7'h00, 15'h0001, 15'h0001},
    {4'd3,  1'b1, 7'h02, 15'h0003, 15'h0103},     // utc, C = 0103
    {4'd5,  1'b1, 7'h00, 15'h0002, 15'h0015},     // 2 + C + M5
    {4'd5,  1'b1, 7'h00, 15'h0002, 15'h7f12},     // C gone again
    {4'd0,  1'b1, 7'h02, 15'h1000, 15'h1000},     // utc, C = 1000
    {4'd3,  1'b1, 7'h04, 15'h0008, 15'h1108},     // vtm with C, M3 = 1008
    {4'd3,  1'b0, 7'h01, 15'h0000, 15'h1008},
    {4'd7,  1'b1, 7'h05, 15'h0040, 15'h0040},     // utm, M7 = 0040
    {4'd7,  1'b1, 7'h05, 15'h0040, 15'h0080},     // utm, M7 = 0080
    {4'd7,  1'b0, 7'h7f, 15'h0fff, 15'h007f},     // short -1 plus M7
    {4'd0,  1'b1, 7'h02, 15'h0000, 15'h0000},     // utc, C = 0
    {4'd7,  1'b1, 7'h02, 15'h0001, 15'h0081},     // utc under C, C = 0081
    {4'd0,  1'b1, 7'h00, 15'h0002, 15'h0083},
    {4'd15, 1'b1, 7'h04, 15'h2222, 15'h2222},     // vtm, M15 = 2222
    {4'd15, 1'b0, 7'h00, 15'h0000, 15'h2222},
    {4'd15, 1'b1, 7'h06, 15'h5dde, 15'h0000}      // wraps to zero
};

// File: tb/mesm6_agu_tb.sv
// Testbench for the address front end: memory model and output back-pressure
// driven from an LFSR, every record checked against the instruction table.
`timescale 1ns/100ps
`default_nettype none
`include "mesm6_cfg.svh"

module mesm6_agu_tb;

    localparam int clk_period   = 10;
    localparam int reset_cycles = 10;

    `include "mesm6_agu_tb_table.svh"

    localparam int n_words        = n_entries / 2;
    localparam int timeout_cycles = reset_cycles + n_entries * 20;

    logic                 clk;
    logic                 reset;
    logic                 fetch_valid;
    logic                 fetch_ready;
    mesm6_pkg::addr_t     fetch_addr;
    logic                 rsp_valid;
    mesm6_pkg::word_t     rsp_word;
    logic                 out_valid;
    logic                 out_ready;
    mesm6_pkg::agu_item_t out_item;

    mesm6_pkg::word_t     mem [0:n_words-1];  // program, from word 0
    mesm6_pkg::agu_item_t rx_q [$];           // records taken off the output
    logic [31:0]          lfsr;
    mesm6_pkg::addr_t     req_addr;           // address of the open request
    int                   delay_cnt;          // cycles until the answer
    logic                 busy;               // memory owes a response
    int                   n_pass;
    int                   n_fail;

    mesm6_agu i_dut (
        .clk(clk), .reset(reset),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
        .rsp_valid(rsp_valid), .rsp_word(rsp_word),
        .out_valid(out_valid), .out_ready(out_ready), .out_item(out_item)
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // Fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];                         // one step per bit
    endtask

    // 24-bit instruction from the table fields
    function automatic mesm6_pkg::insn_t make_insn(input entry_t e);
        if (e.lflag) begin
            return {e.ir, 1'b1, e.cmd[3:0], e.addr};
        end
        return {e.ir, 1'b0, e.cmd, e.addr[11:0]};
    endfunction

    // past the program, a pattern built from the whole address
    function automatic mesm6_pkg::word_t word_at(input mesm6_pkg::addr_t a);
        if (int'(a) < n_words) begin
            return mem[int'(a)];
        end
        return {~a, 9'h1a5, a, 9'h05a};
    endfunction

    task automatic check_record(input int i, input mesm6_pkg::agu_item_t got);
        mesm6_pkg::hpc_t  exp_hpc;
        mesm6_pkg::insn_t exp_insn;
        mesm6_pkg::addr_t exp_uaddr;
        int               errs;
        exp_hpc   = `MESM6_RESET_PC + mesm6_pkg::hpc_t'(i);    // one half per entry
        exp_insn  = make_insn(entry_table[i]);
        exp_uaddr = entry_table[i].uaddr;
        errs      = 0;
        assert (got.hpc == exp_hpc) else begin
            $display("ERROR @%0t: entry %0d hpc %h, expected %h", $time, i, got.hpc, exp_hpc);
            errs++;
        end
        assert (got.insn == exp_insn) else begin
            $display("ERROR @%0t: entry %0d insn %h, expected %h", $time, i, got.insn,
                     exp_insn);
            errs++;
        end
        assert (got.uaddr == exp_uaddr) else begin
            $display("ERROR @%0t: entry %0d uaddr %h, expected %h", $time, i, got.uaddr,
                     exp_uaddr);
            errs++;
        end
        if (errs == 0) begin
            n_pass++;
            $display("entry %2d hpc %h uaddr %h ok", i, got.hpc, got.uaddr);
        end else begin
            n_fail++;
            $display("entry %2d FAILED with %0d mismatches", i, errs);
        end
    endtask

    // ------------------------------------------------------------------------
    // clock, reset, memory model and output ready
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : drive
        logic b0;
        logic b1;
        reset       = 1'b1;
        fetch_ready = 1'b0;
        rsp_valid   = 1'b0;
        rsp_word    = '0;
        out_ready   = 1'b0;
        busy        = 1'b0;
        delay_cnt   = 0;
        req_addr    = '0;
        lfsr        = 32'hc78e_2877;
        for (int k = 0; k < n_words; k++) begin
            mem[k] = {make_insn(entry_table[2*k]), make_insn(entry_table[2*k+1])};
        end
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        forever begin
            rsp_valid = 1'b0;                   // one-cycle response pulse
            if (busy) begin
                delay_cnt--;
                if (delay_cnt == 0) begin
                    rsp_valid = 1'b1;
                    rsp_word  = word_at(req_addr);
                    busy      = 1'b0;
                end
            end
            fetch_ready = 1'b0;
            if (!busy && !rsp_valid) begin      // one request in flight
                random_bit(b0);
                fetch_ready = b0;
                if (fetch_valid && fetch_ready) begin
                    req_addr = fetch_addr;
                    random_bit(b0);
                    random_bit(b1);
                    delay_cnt = 1 + 2 * int'(b1) + int'(b0);   // 1..4 cycles
                    busy      = 1'b1;
                end
            end
            random_bit(b0);
            out_ready = b0;
            if (out_valid && out_ready) begin
                rx_q.push_back(out_item);       // moves on the next rising edge
            end
            @(negedge clk);
        end
    end

    // ------------------------------------------------------------------------
    // checks in table order, then the report
    // ------------------------------------------------------------------------
    initial begin : check
        mesm6_pkg::agu_item_t got;
        n_pass = 0;
        n_fail = 0;
        for (int i = 0; i < n_entries; i++) begin
            while (rx_q.size() == 0) begin
                @(posedge clk);
            end
            got = rx_q.pop_front();
            check_record(i, got);
        end
        $display("%0d tests, %0d passed, %0d failed", n_entries, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the DUT did not deliver all %0d records within %0d cycles",
                 n_entries, timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: mesm6_agu.f
+incdir+common
+incdir+tb
common/mesm6_pkg.sv
hw/mesm6_stage_reg.sv
hw/fetch/mesm6_fetch.sv
hw/decode/mesm6_index_regs.sv
hw/decode/mesm6_decode.sv
hw/mesm6_agu.sv
tb/mesm6_agu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the mesm6_agu testbench with Verilator, then check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mesm6_agu_tb \
    -f mesm6_agu.f

./obj_dir/Vmesm6_agu_tb 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
